// File: dv/tb_ay_psg.sv
// Sound generator testbench
`timescale 1ns/10ps
`default_nettype none

`include "ay_consts.svh"

module tb_ay_psg;
    import ay_pkg::*;

    // Kinds of table entries
    localparam int K_IDLE    = 0;
    localparam int K_LEVEL   = 1;
    localparam int K_RAND    = 2;
    localparam int K_TONE    = 3;
    localparam int K_NOISE   = 4;
    localparam int N_ENTRIES = 14;

    // Each test step holds its kind, channel, period argument, amplitudes {C,B,A} and expected value
    typedef struct packed {
        int              kind;
        int              ch;
        int              arg;
        logic [2:0][3:0] amp;
        int              want;
    } entry_t;

    logic       clk;
    logic       reset;
    logic       wr;
    logic [3:0] addr;
    logic [7:0] data;
    audio_t     audio;

    int         seed = 32'h4762_9590;
    entry_t     tbl [N_ENTRIES];

    // Reference noise model state paced by its own tick
    int                     m_div;
    logic                   m_tick;
    logic [`AY_NOISE_W-1:0] m_nper;
    logic [`AY_NOISE_W-1:0] m_ncount;
    logic [`AY_CRC_W-1:0]   m_crc;
    int                     m_steps;

    ay_psg dut0 (
        .clk   (clk),
        .reset (reset),
        .wr    (wr),
        .addr  (addr),
        .data  (data),
        .audio (audio)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // **************************************************
    // Reference model of tick and noise CRC
    // **************************************************
    function automatic logic [`AY_CRC_W-1:0] crc_next(input logic [`AY_CRC_W-1:0] c,
                                                      input logic d);
        logic                 fb;
        logic [`AY_CRC_W-1:0] n;
        fb = c[`AY_CRC_W-1] ^ d;
        n  = {c[`AY_CRC_W-2:0], 1'b0};
        if (fb)
            n = n ^ `AY_CRC_POLY;
        return n;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            m_div    <= 0;
            m_tick   <= 1'b0;
            m_nper   <= '0;
            m_ncount <= '0;
            m_crc    <= `AY_CRC_INIT;
            m_steps  <= 0;
        end else begin
            m_div  <= (m_div == `AY_CLK_DIV - 1) ? 0 : m_div + 1;
            m_tick <= (m_div == `AY_CLK_DIV - 1);
            if (wr && addr == REG_NOISE_PERIOD)
                m_nper <= data[`AY_NOISE_W-1:0];
            // Noise steps on a tick that finds the counter empty
            if (m_tick) begin
                if (m_ncount == '0) begin
                    m_ncount <= m_nper;
                    m_crc    <= crc_next(m_crc, m_nper[0]);
                    m_steps  <= m_steps + 1;
                end else begin
                    m_ncount <= m_ncount - 1'b1;
                end
            end
        end
    end

    // **************************************************
    // Bus and check helpers
    // **************************************************
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
        @(posedge clk);
        wr   <= 1'b1;
        addr <= a;
        data <= d;
        @(posedge clk);
        wr   <= 1'b0;
    endtask

    task automatic check_audio(input int expected, input string what);
        assert (int'(audio) == expected)
        else abort_run($sformatf("[FAIL] %0d ns: %s, audio %0d expected %0d",
                                 $time, what, audio, expected));
    endtask

    // Counts cycles until audio moves away from its present value
    task automatic wait_change(input int limit, input string what, output int n);
        audio_t prev;
        prev = audio;
        n    = 0;
        while (audio == prev && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (audio == prev)
            abort_run($sformatf("Timeout while waiting for %s", what));
    endtask

    task automatic wait_step(input int limit);
        int start;
        int n;
        start = m_steps;
        n     = 0;
        while (m_steps == start && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (m_steps == start)
            abort_run("Timeout while waiting for the next noise step");
    endtask

    // **************************************************
    // Test steps
    // **************************************************
    task automatic check_idle(input int ticks);
        for (int k = 0; k < ticks * `AY_CLK_DIV; k++) begin
            @(posedge clk);
            check_audio(0, "idle after reset");
        end
    endtask

    // With all sources disabled every channel just plays its amplitude
    task automatic check_level(input logic [11:0] amps, input int expected);
        write_reg(REG_MIXER, 8'h3F);
        for (int i = 0; i < 3; i++)
            write_reg(4'(REG_AMP_A + i), {4'h0, amps[4*i +: 4]});
        repeat (2) @(posedge clk);
        check_audio(expected, "constant level");
    endtask

    task automatic check_tone(input int ch, input int period, input int ticks);
        logic [5:0] mixer;
        audio_t     prev;
        int         n;
        int         limit;
        limit = 2 * ticks * `AY_CLK_DIV + 32;
        mixer = {3'b111, 3'b111 & ~(3'b001 << ch)};
        for (int i = 0; i < 3; i++)
            write_reg(4'(REG_AMP_A + i), (i == ch) ? 8'h0F : 8'h00);
        write_reg(REG_MIXER, {2'b00, mixer});
        write_reg(4'(REG_TONE_A_FINE + 2 * ch), 8'(period));
        write_reg(4'(REG_TONE_A_COARSE + 2 * ch), 8'(period >> 8));
        // Other channels and the unused addresses must not touch this period
        for (int i = 0; i < 3; i++) begin
            if (i != ch) begin
                write_reg(4'(2 * i), 8'hFF);
                write_reg(4'(2 * i + 1), 8'hFF);
            end
        end
        for (int a = 11; a < 16; a++)
            write_reg(4'(a), 8'hFF);
        repeat (3) @(posedge clk);
        wait_change(limit, "the first tone edge", n);
        for (int k = 0; k < 4; k++) begin
            prev = audio;
            wait_change(limit, "a tone edge", n);
            assert (n == ticks * `AY_CLK_DIV)
            else abort_run($sformatf(
                "[FAIL] %0d ns: channel %0d level lasted %0d cycles, expected %0d",
                $time, ch, n, ticks * `AY_CLK_DIV));
            assert ((prev == 6'd0 && audio == 6'd15) || (prev == 6'd15 && audio == 6'd0))
            else abort_run($sformatf("[FAIL] %0d ns: tone went from %0d to %0d",
                                     $time, prev, audio));
        end
    endtask

    task automatic check_noise(input int period, input int steps);
        int half;
        int limit;
        half  = (period + 1) * `AY_CLK_DIV / 2;
        limit = 64 * `AY_CLK_DIV;
        write_reg(REG_AMP_A, 8'h0F);
        write_reg(REG_AMP_B, 8'h00);
        write_reg(REG_AMP_C, 8'h00);
        write_reg(REG_MIXER, 8'h37);
        write_reg(REG_NOISE_PERIOD, 8'(period));
        // The counter may still run out an old period first
        wait_step(limit);
        wait_step(limit);
        for (int k = 0; k < steps; k++) begin
            wait_step(limit);
            repeat (half) @(posedge clk);
            check_audio(m_crc[`AY_CRC_W-1] ? 15 : 0, "noise level");
        end
    endtask

    task automatic load_table();
        tbl[0]  = '{K_IDLE,  0, 0,      12'h000, 20};
        tbl[1]  = '{K_LEVEL, 0, 0,      12'h321, 6};
        tbl[2]  = '{K_LEVEL, 0, 0,      12'hFFF, 45};
        tbl[3]  = '{K_LEVEL, 0, 0,      12'h970, 16};
        tbl[4]  = '{K_RAND,  0, 0,      12'h000, 0};
        tbl[5]  = '{K_RAND,  0, 0,      12'h000, 0};
        // Half period 0 plays like 1
        tbl[6]  = '{K_TONE,  0, 0,      12'h000, 1};
        tbl[7]  = '{K_TONE,  0, 1,      12'h000, 1};
        tbl[8]  = '{K_TONE,  0, 5,      12'h000, 5};
        tbl[9]  = '{K_TONE,  1, 'h123,  12'h000, 291};
        tbl[10] = '{K_TONE,  2, 'h0A7,  12'h000, 167};
        tbl[11] = '{K_NOISE, 0, 0,      12'h000, 30};
        tbl[12] = '{K_NOISE, 0, 3,      12'h000, 30};
        tbl[13] = '{K_NOISE, 0, 6,      12'h000, 30};
    endtask

    initial begin
        entry_t e;
        int     r;
        reset = 1'b1;
        wr    = 1'b0;
        addr  = '0;
        data  = '0;
        load_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            e = tbl[i];
            case (e.kind)
                K_IDLE:  check_idle(e.want);
                K_LEVEL: check_level(e.amp, e.want);
                K_RAND: begin
                    r = $random(seed);
                    check_level(12'(r), int'(r[3:0]) + int'(r[7:4]) + int'(r[11:8]));
                end
                K_TONE:  check_tone(e.ch, e.arg, e.want);
                K_NOISE: check_noise(e.arg, e.want);
                default: abort_run("Unknown kind of table entry");
            endcase
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/ay_clock_div.sv
// AY tick prescaler
`timescale 1ns/10ps
`default_nettype none

`include "ay_consts.svh"

module ay_clock_div (
    input  logic clk,
    input  logic reset,
    output logic tick
);
    localparam int CW = $clog2(`AY_CLK_DIV);

    logic [CW-1:0] count;

    // Free running modulo counter, the tick is its registered terminal count
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            count <= (count == CW'(`AY_CLK_DIV - 1)) ? '0 : count + 1'b1;
            tick  <= (count == CW'(`AY_CLK_DIV - 1));
        end
    end

endmodule

`default_nettype wire

// File: rtl/ay_consts.svh
// Sound generator constants
`ifndef AY_CONSTS_SVH
`define AY_CONSTS_SVH

// System clock cycles per AY tick
`define AY_CLK_DIV 8

// Register field and datapath widths
`define AY_TONE_W 12
`define AY_NOISE_W 5
`define AY_AMP_W 4
`define AY_AUDIO_W 6

// Noise CRC: a CDMA2000 style polynomial run on its own output
`define AY_CRC_W 16
`define AY_CRC_POLY 16'hC867
`define AY_CRC_INIT 16'hFFFF

`endif

// File: rtl/ay_crc.sv
// Serial CRC register
`timescale 1ns/10ps
`default_nettype none

module ay_crc #(
    parameter int             BITS = 16,
    parameter logic [BITS-1:0] POLY = '0,
    parameter logic [BITS-1:0] INIT = '1
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            enable,
    input  logic            data,
    output logic [BITS-1:0] crc_out
);

    logic            feedback;
    logic [BITS-1:0] crc_next;

    // MSB first, the bit leaving the top is folded with the incoming data
    assign feedback = crc_out[BITS-1] ^ data;

    // Shift left and fold the polynomial back in when the feedback is set
    assign crc_next = {crc_out[BITS-2:0], 1'b0} ^ (feedback ? POLY : '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            crc_out <= INIT;
        end else if (enable) begin
            crc_out <= crc_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ay_mixer.sv
// Channel mixer
`timescale 1ns/10ps
`default_nettype none

module ay_mixer (
    input  logic           clk,
    input  logic           reset,
    input  logic [2:0]     square,
    input  logic           noise,
    ay_regs_if.sound       regs,
    output ay_pkg::audio_t audio
);
    import ay_pkg::*;

    logic [2:0] chan_on;
    amp_t       level [0:2];
    audio_t     sum;

    // **************************************************
    // Gating and volume
    // **************************************************
    always_comb begin
        sum = '0;
        for (int i = 0; i < 3; i++) begin
            // A disabled source is treated as stuck high so it never mutes
            chan_on[i] = (square[i] | regs.tone_off[i]) & (noise | regs.noise_off[i]);
            level[i]   = chan_on[i] ? regs.amp[i] : '0;
            sum        = sum + audio_t'(level[i]);
        end
    end

    // Output register, linear sum of the three volumes
    always_ff @(posedge clk) begin
        if (reset) begin
            audio <= '0;
        end else begin
            audio <= sum;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ay_noise.sv
// Noise source
`timescale 1ns/10ps
`default_nettype none

`include "ay_consts.svh"

module ay_noise (
    input  logic     clk,
    input  logic     reset,
    input  logic     tick,
    ay_regs_if.sound regs,
    output logic     noise
);

    logic [`AY_NOISE_W-1:0] count;
    logic                   step;
    logic [`AY_CRC_W-1:0]   crc_out;

    // The CRC moves in the cycle right after a tick that finds the counter empty
    assign step = tick && (count == '0);

    // Period counter only runs on ticks, so the noise rate follows the period
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (tick) begin
            count <= (count == '0) ? regs.noise_period : count - 1'b1;
        end
    end

    // **************************************************
    // Pseudo random generator
    // **************************************************
    ay_crc #(
        .BITS (`AY_CRC_W),
        .POLY (`AY_CRC_POLY),
        .INIT (`AY_CRC_INIT)
    ) crc_0 (
        .clk     (clk),
        .reset   (reset),
        .enable  (step),
        .data    (regs.noise_period[0]),
        .crc_out (crc_out)
    );

    assign noise = crc_out[`AY_CRC_W-1];

endmodule

`default_nettype wire

// File: rtl/ay_pkg.sv
// Sound generator shared types
`default_nettype none

`include "ay_consts.svh"

package ay_pkg;

    // Register addresses as seen on the external write port
    typedef enum logic [3:0] {
        REG_TONE_A_FINE   = 4'd0,
        REG_TONE_A_COARSE = 4'd1,
        REG_TONE_B_FINE   = 4'd2,
        REG_TONE_B_COARSE = 4'd3,
        REG_TONE_C_FINE   = 4'd4,
        REG_TONE_C_COARSE = 4'd5,
        REG_NOISE_PERIOD  = 4'd6,
        REG_MIXER         = 4'd7,
        REG_AMP_A         = 4'd8,
        REG_AMP_B         = 4'd9,
        REG_AMP_C         = 4'd10
    } ay_reg_e;

    typedef logic [`AY_TONE_W-1:0]  tone_period_t;
    typedef logic [`AY_AMP_W-1:0]   amp_t;
    typedef logic [`AY_AUDIO_W-1:0] audio_t;

endpackage

`default_nettype wire

// File: rtl/ay_psg.sv
// Programmable sound generator top
`timescale 1ns/10ps
`default_nettype none

module ay_psg (
    input  logic           clk,
    input  logic           reset,
    input  logic           wr,
    input  logic [3:0]     addr,
    input  logic [7:0]     data,
    output ay_pkg::audio_t audio
);

    logic       tick;
    logic [2:0] square;
    logic       noise;

    // Decoded settings shared by every sound block
    ay_regs_if regs_bus ();

    // **************************************************
    // Control
    // **************************************************
    ay_regs regs_0 (
        .clk   (clk),
        .reset (reset),
        .wr    (wr),
        .addr  (addr),
        .data  (data),
        .regs  (regs_bus.regs)
    );

    ay_clock_div clock_div_0 (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    // **************************************************
    // Sound sources
    // **************************************************
    // One tone channel per index, A is bit 0 of the square vector
    for (genvar i = 0; i < 3; i++) begin : g_tone
        ay_tone tone_0 (
            .clk    (clk),
            .reset  (reset),
            .tick   (tick),
            .period (regs_bus.tone_period[i]),
            .square (square[i])
        );
    end

    ay_noise noise_0 (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .regs  (regs_bus.sound),
        .noise (noise)
    );

    ay_mixer mixer_0 (
        .clk    (clk),
        .reset  (reset),
        .square (square),
        .noise  (noise),
        .regs   (regs_bus.sound),
        .audio  (audio)
    );

endmodule

`default_nettype wire

// File: rtl/ay_regs.sv
// Register file
`timescale 1ns/10ps
`default_nettype none

`include "ay_consts.svh"

module ay_regs (
    input  logic       clk,
    input  logic       reset,
    input  logic       wr,
    input  logic [3:0] addr,
    input  logic [7:0] data,
    ay_regs_if.regs    regs
);
    import ay_pkg::*;

    // Raw register storage, already trimmed to the bits the chip keeps
    logic [7:0]                   tone_fine [0:2];
    logic [`AY_TONE_W-9:0]        tone_coarse [0:2];
    logic [`AY_NOISE_W-1:0]       noise_period;
    logic [5:0]                   mixer;
    amp_t                         amp [0:2];

    // **************************************************
    // Write decode
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 3; i++) begin
                tone_fine[i]   <= '0;
                tone_coarse[i] <= '0;
                amp[i]         <= '0;
            end
            noise_period <= '0;
            mixer        <= '0;
        end else if (wr) begin
            // Addresses 11 to 15 fall through to the default and are dropped
            case (ay_reg_e'(addr))
                REG_TONE_A_FINE:   tone_fine[0]   <= data;
                REG_TONE_A_COARSE: tone_coarse[0] <= data[`AY_TONE_W-9:0];
                REG_TONE_B_FINE:   tone_fine[1]   <= data;
                REG_TONE_B_COARSE: tone_coarse[1] <= data[`AY_TONE_W-9:0];
                REG_TONE_C_FINE:   tone_fine[2]   <= data;
                REG_TONE_C_COARSE: tone_coarse[2] <= data[`AY_TONE_W-9:0];
                REG_NOISE_PERIOD:  noise_period   <= data[`AY_NOISE_W-1:0];
                REG_MIXER:         mixer          <= data[5:0];
                // The envelope mode bit 4 is not kept
                REG_AMP_A:         amp[0]         <= data[`AY_AMP_W-1:0];
                REG_AMP_B:         amp[1]         <= data[`AY_AMP_W-1:0];
                REG_AMP_C:         amp[2]         <= data[`AY_AMP_W-1:0];
                default: ;
            endcase
        end
    end

    // **************************************************
    // Settings presented to the sound blocks
    // **************************************************
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            // Coarse byte forms the upper nibble of the half period
            regs.tone_period[i] = {tone_coarse[i], tone_fine[i]};
            regs.amp[i]         = amp[i];
        end
    end

    assign regs.noise_period = noise_period;
    assign regs.tone_off     = mixer[2:0];
    assign regs.noise_off    = mixer[5:3];

endmodule

`default_nettype wire

// File: rtl/ay_regs_if.sv
// Decoded register bus
`timescale 1ns/10ps
`default_nettype none

`include "ay_consts.svh"

interface ay_regs_if;
    import ay_pkg::*;

    // Half period of each tone channel, A at index 0
    tone_period_t              tone_period [0:2];
    logic [`AY_NOISE_W-1:0]    noise_period;
    // Mixer disables, one bit per channel, set means off
    logic [2:0]                tone_off;
    logic [2:0]                noise_off;
    // Linear channel volumes
    amp_t                      amp [0:2];

    // The register file is the only writer
    modport regs (
        output tone_period, noise_period, tone_off, noise_off, amp
    );

    // Tone, noise and mixer blocks only look at the settings
    modport sound (
        input tone_period, noise_period, tone_off, noise_off, amp
    );

endinterface

`default_nettype wire

// File: rtl/ay_tone.sv
// Square wave tone channel
`timescale 1ns/10ps
`default_nettype none

module ay_tone (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tick,
    input  ay_pkg::tone_period_t period,
    output logic                 square
);
    import ay_pkg::*;

    tone_period_t count;
    tone_period_t last;

    // Period 0 behaves like period 1, so the last count value is period - 1
    // and never wraps below zero
    assign last = (period == '0) ? '0 : period - 1'b1;

    // **************************************************
    // Half period counter
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            count  <= '0;
            square <= 1'b0;
        end else if (tick) begin
            // A compare with >= recovers at once when the period shrinks
            // below the current count
            if (count >= last) begin
                count  <= '0;
                square <= ~square;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_ay_psg -o tb_ay_psg_sim

out=$(./obj_dir/tb_ay_psg_sim || true)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// File: sources.f
+incdir+rtl
rtl/ay_pkg.sv
rtl/ay_regs_if.sv
rtl/ay_regs.sv
rtl/ay_clock_div.sv
rtl/ay_tone.sv
rtl/ay_crc.sv
rtl/ay_noise.sv
rtl/ay_mixer.sv
rtl/ay_psg.sv
dv/tb_ay_psg.sv
